// File: hdl/usb_phy_settings.svh
// Register map, data widths and bus-reset timing of the USB PHY front end, included by the package and modules
`ifndef USB_PHY_SETTINGS_SVH
`define USB_PHY_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Register port geometry
//////////////////////////////////////////////////////////////////////

// Word address width, four slots
`define USB_REG_AW 2
// Data word width
`define USB_REG_DW 16

// Register map
`define USB_ADDR_DRIVE 0
`define USB_ADDR_SENSE 1
`define USB_ADDR_LINE 2

//////////////////////////////////////////////////////////////////////
// Line monitor
//////////////////////////////////////////////////////////////////////

// Consecutive synchronized SE0 cycles that make a bus reset
`define USB_BUS_RESET_CYCLES 16

`endif

// File: hdl/usb_phy_pkg.sv
// Types shared by the USB PHY front end, referenced by scoped name from every module and the testbench
`include "usb_phy_settings.svh"

package usb_phy_pkg;

  // Register port words
  typedef logic [`USB_REG_AW-1:0] reg_addr_t;
  typedef logic [`USB_REG_DW-1:0] reg_data_t;

  // Run counter for SE0 cycles, wide enough to hold the threshold itself
  typedef logic [$clog2(`USB_BUS_RESET_CYCLES + 1)-1:0] se0_cnt_t;

  // Transmit bundle, same layout on the engine side and the pin side
  typedef struct packed {
    logic d;
    logic se0;
    logic dp;
    logic dn;
    logic oe;
  } usb_tx_pins_t;

  // Pull-ups and receiver enable
  typedef struct packed {
    logic dp_pullup_en;
    logic dn_pullup_en;
    logic rx_enable;
  } usb_ctrl_pins_t;

  // Receive bundle, async at the pins and synchronized towards the engine
  typedef struct packed {
    logic d;
    logic dp;
    logic dn;
    logic pwr_sense;
  } usb_rx_pins_t;

  // Drive register, bit 8 down to bit 0
  typedef struct packed {
    logic en;
    logic oe;
    logic se0;
    logic dn;
    logic dp;
    logic d;
    logic rx_enable;
    logic dn_pullup_en;
    logic dp_pullup_en;
  } usb_drive_t;

  // Sense register, bit 8 down to bit 0
  typedef struct packed {
    logic tx_oe;
    logic tx_se0;
    logic tx_dn;
    logic tx_dp;
    logic tx_d;
    logic pwr_sense;
    logic rx_dn;
    logic rx_dp;
    logic rx_d;
  } usb_sense_t;

  // Line state, J is dp high with dn low
  typedef enum logic [1:0] {
    SE0 = 2'd0,
    J   = 2'd1,
    K   = 2'd2,
    SE1 = 2'd3
  } line_state_e;

endpackage

// File: hdl/usb_phy_regs.sv
// Software register file of the PHY front end, holding the override drive word, pin sense and line status
`timescale 1ns/1ns
`include "usb_phy_settings.svh"

module usb_phy_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // Register port, write strobe with combinational read
  input  logic                     reg_wr_i,
  input  usb_phy_pkg::reg_addr_t   reg_addr_i,
  input  usb_phy_pkg::reg_data_t   reg_wdata_i,
  output usb_phy_pkg::reg_data_t   reg_rdata_o,

  // Status coming back from the mux and the monitor
  input  usb_phy_pkg::usb_sense_t  sense_i,
  input  usb_phy_pkg::line_state_e line_state_i,
  input  logic                     bus_reset_i,

  // Override word towards the mux
  output usb_phy_pkg::usb_drive_t  drive_o
);

  // Decoded addresses in the port's own width
  localparam usb_phy_pkg::reg_addr_t ADDR_DRIVE = usb_phy_pkg::reg_addr_t'(`USB_ADDR_DRIVE);
  localparam usb_phy_pkg::reg_addr_t ADDR_SENSE = usb_phy_pkg::reg_addr_t'(`USB_ADDR_SENSE);
  localparam usb_phy_pkg::reg_addr_t ADDR_LINE  = usb_phy_pkg::reg_addr_t'(`USB_ADDR_LINE);

  // Line register layout
  localparam int unsigned LINE_FLAG_BIT = 2;

  // Field widths inside the data word
  localparam int unsigned DRIVE_W = $bits(usb_phy_pkg::usb_drive_t);
  localparam int unsigned SENSE_W = $bits(usb_phy_pkg::usb_sense_t);

  usb_phy_pkg::usb_drive_t drive_q;
  logic                    bus_reset_flag_q;
  logic                    wr_drive;
  logic                    wr_line;

  //////////////////////////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////////////////////////

  // Sense and the spare slot take no writes
  assign wr_drive = reg_wr_i && (reg_addr_i == ADDR_DRIVE);
  assign wr_line  = reg_wr_i && (reg_addr_i == ADDR_LINE);

  // Drive register, low 9 bits of the word
  // Cleared to zero so the pins follow the engine out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      drive_q <= '0;
    end else if (wr_drive) begin
      drive_q <= usb_phy_pkg::usb_drive_t'(reg_wdata_i[DRIVE_W-1:0]);
    end
  end

  // Sticky bus-reset flag
  // A pulse in the same cycle as a clear keeps the flag set
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bus_reset_flag_q <= 1'b0;
    end else if (bus_reset_i) begin
      bus_reset_flag_q <= 1'b1;
    end else if (wr_line && reg_wdata_i[LINE_FLAG_BIT]) begin
      bus_reset_flag_q <= 1'b0;
    end
  end

  assign drive_o = drive_q;

  //////////////////////////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////////////////////////

  // Same-cycle read, unused bits read as zero
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      ADDR_DRIVE: begin
        reg_rdata_o[DRIVE_W-1:0] = drive_q;
      end
      ADDR_SENSE: begin
        // Synchronized rx plus the engine's own tx request
        reg_rdata_o[SENSE_W-1:0] = sense_i;
      end
      ADDR_LINE: begin
        reg_rdata_o[1:0]           = line_state_i;
        reg_rdata_o[LINE_FLAG_BIT] = bus_reset_flag_q;
      end
      default: begin
        reg_rdata_o = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Monitor only reports a reset while the decoded line is still SE0
  a_bus_reset_on_se0 : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    bus_reset_i |-> (line_state_i == usb_phy_pkg::SE0)
  );

endmodule

// File: hdl/usb_phy_iomux.sv
// Pin mux of the PHY front end: receive synchronizer, transmit and control override select, sense bundle
`timescale 1ns/1ns

module usb_phy_iomux (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // Override word from the register file
  input  usb_phy_pkg::usb_drive_t     drive_i,

  // Async receive pins
  input  usb_phy_pkg::usb_rx_pins_t   usb_rx_i,

  // Engine requests
  input  usb_phy_pkg::usb_tx_pins_t   eng_tx_i,
  input  usb_phy_pkg::usb_ctrl_pins_t eng_ctrl_i,

  // Synchronized receive lines, clk_i domain
  output usb_phy_pkg::usb_rx_pins_t   rx_sync_o,

  // Pin side
  output usb_phy_pkg::usb_tx_pins_t   usb_tx_o,
  output usb_phy_pkg::usb_ctrl_pins_t usb_ctrl_o,

  // Sense bundle back to the register file
  output usb_phy_pkg::usb_sense_t     sense_o
);

  usb_phy_pkg::usb_rx_pins_t   rx_meta_q;
  usb_phy_pkg::usb_rx_pins_t   rx_sync_q;
  usb_phy_pkg::usb_tx_pins_t   drive_tx;
  usb_phy_pkg::usb_ctrl_pins_t drive_ctrl;

  //////////////////////////////////////////////////////////////////////
  // Receive synchronizer
  //////////////////////////////////////////////////////////////////////

  // Two flops, so a pin change shows up two edges later
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_meta_q <= '0;
      rx_sync_q <= '0;
    end else begin
      rx_meta_q <= usb_rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  assign rx_sync_o = rx_sync_q;

  //////////////////////////////////////////////////////////////////////
  // Transmit and control select
  //////////////////////////////////////////////////////////////////////

  // Regroup the flat drive word into pin bundles
  assign drive_tx.d   = drive_i.d;
  assign drive_tx.se0 = drive_i.se0;
  assign drive_tx.dp  = drive_i.dp;
  assign drive_tx.dn  = drive_i.dn;
  assign drive_tx.oe  = drive_i.oe;

  assign drive_ctrl.dp_pullup_en = drive_i.dp_pullup_en;
  assign drive_ctrl.dn_pullup_en = drive_i.dn_pullup_en;
  assign drive_ctrl.rx_enable    = drive_i.rx_enable;

  // Plain combinational mux, no glitch-free cells
  always_comb begin
    if (drive_i.en) begin
      usb_tx_o   = drive_tx;
      usb_ctrl_o = drive_ctrl;
    end else begin
      usb_tx_o   = eng_tx_i;
      usb_ctrl_o = eng_ctrl_i;
    end
  end

  // Sense reports the engine request, not what reaches the pins
  assign sense_o.tx_oe     = eng_tx_i.oe;
  assign sense_o.tx_se0    = eng_tx_i.se0;
  assign sense_o.tx_dn     = eng_tx_i.dn;
  assign sense_o.tx_dp     = eng_tx_i.dp;
  assign sense_o.tx_d      = eng_tx_i.d;
  assign sense_o.pwr_sense = rx_sync_q.pwr_sense;
  assign sense_o.rx_dn     = rx_sync_q.dn;
  assign sense_o.rx_dp     = rx_sync_q.dp;
  assign sense_o.rx_d      = rx_sync_q.d;

  // Override on, the pins carry the register fields
  a_override_follows_drive : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    drive_i.en |-> (usb_tx_o == {drive_i.d, drive_i.se0, drive_i.dp, drive_i.dn, drive_i.oe}) &&
                   (usb_ctrl_o == {drive_i.dp_pullup_en, drive_i.dn_pullup_en,
                                   drive_i.rx_enable})
  );

  // Override off, the pins carry the engine request
  a_passthrough_follows_engine : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !drive_i.en |-> (usb_tx_o == eng_tx_i) && (usb_ctrl_o == eng_ctrl_i)
  );

endmodule

// File: hdl/usb_line_monitor.sv
// Line monitor of the PHY front end: decodes SE0/J/K/SE1 from synchronized lines and flags a long SE0 as bus reset
`timescale 1ns/1ns
`include "usb_phy_settings.svh"

module usb_line_monitor (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  // Synchronized receive lines
  input  usb_phy_pkg::usb_rx_pins_t rx_sync_i,

  // Decoded state and single-cycle reset pulse
  output usb_phy_pkg::line_state_e  line_state_o,
  output logic                      bus_reset_o
);

  // Threshold in counter width
  localparam usb_phy_pkg::se0_cnt_t RESET_CYCLES =
    usb_phy_pkg::se0_cnt_t'(`USB_BUS_RESET_CYCLES);

  usb_phy_pkg::se0_cnt_t se0_cnt_q;
  usb_phy_pkg::se0_cnt_t se0_cnt_d;
  logic                  line_se0;

  //////////////////////////////////////////////////////////////////////
  // Line decode
  //////////////////////////////////////////////////////////////////////

  // Straight from the synchronizer, no extra flop
  always_comb begin
    case ({rx_sync_i.dn, rx_sync_i.dp})
      2'b00:   line_state_o = usb_phy_pkg::SE0;
      2'b01:   line_state_o = usb_phy_pkg::J;
      2'b10:   line_state_o = usb_phy_pkg::K;
      default: line_state_o = usb_phy_pkg::SE1;
    endcase
  end

  assign line_se0 = (line_state_o == usb_phy_pkg::SE0);

  //////////////////////////////////////////////////////////////////////
  // SE0 run counter
  //////////////////////////////////////////////////////////////////////

  // Counts the current cycle too, holds at the threshold
  // Any non-SE0 cycle restarts the run
  always_comb begin
    se0_cnt_d = '0;
    if (line_se0) begin
      if (se0_cnt_q == RESET_CYCLES) begin
        se0_cnt_d = se0_cnt_q;
      end else begin
        se0_cnt_d = se0_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      se0_cnt_q <= '0;
    end else begin
      se0_cnt_q <= se0_cnt_d;
    end
  end

  // High in the cycle whose edge takes the count to the threshold
  // Saturation keeps it to one pulse per run
  assign bus_reset_o = line_se0 && (se0_cnt_d == RESET_CYCLES) &&
                       (se0_cnt_q != RESET_CYCLES);

  // One pulse per SE0 run, never a level
  a_bus_reset_single : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    bus_reset_o |=> !bus_reset_o
  );

endmodule

// File: hdl/usb_phy_top.sv
// Top level of the USB PHY front end, tying register file, pin mux and line monitor to the pins and the engine
`timescale 1ns/1ns

module usb_phy_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // Register port
  input  logic                        reg_wr_i,
  input  usb_phy_pkg::reg_addr_t      reg_addr_i,
  input  usb_phy_pkg::reg_data_t      reg_wdata_i,
  output usb_phy_pkg::reg_data_t      reg_rdata_o,

  // Async receive pins
  input  usb_phy_pkg::usb_rx_pins_t   usb_rx_i,

  // Engine side
  input  usb_phy_pkg::usb_tx_pins_t   eng_tx_i,
  input  usb_phy_pkg::usb_ctrl_pins_t eng_ctrl_i,
  output usb_phy_pkg::usb_rx_pins_t   eng_rx_o,
  output usb_phy_pkg::line_state_e    eng_line_state_o,
  output logic                        eng_bus_reset_o,

  // Pin side
  output usb_phy_pkg::usb_tx_pins_t   usb_tx_o,
  output usb_phy_pkg::usb_ctrl_pins_t usb_ctrl_o
);

  usb_phy_pkg::usb_drive_t   drive;
  usb_phy_pkg::usb_sense_t   sense;
  usb_phy_pkg::usb_rx_pins_t rx_sync;

  // Registers steer the mux and latch monitor status
  usb_phy_regs u_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .reg_wr_i     (reg_wr_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .sense_i      (sense),
    .line_state_i (eng_line_state_o),
    .bus_reset_i  (eng_bus_reset_o),
    .drive_o      (drive)
  );

  // Synchronizer and override mux
  usb_phy_iomux u_iomux (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .drive_i    (drive),
    .usb_rx_i   (usb_rx_i),
    .eng_tx_i   (eng_tx_i),
    .eng_ctrl_i (eng_ctrl_i),
    .rx_sync_o  (rx_sync),
    .usb_tx_o   (usb_tx_o),
    .usb_ctrl_o (usb_ctrl_o),
    .sense_o    (sense)
  );

  // Engine sees the same synchronized lines as the monitor
  assign eng_rx_o = rx_sync;

  usb_line_monitor u_line_monitor (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rx_sync_i    (rx_sync),
    .line_state_o (eng_line_state_o),
    .bus_reset_o  (eng_bus_reset_o)
  );

endmodule

// File: test/usb_phy_tb.sv
// Self-checking testbench for the USB PHY front end that runs random stimulus against a cycle model
`timescale 1ns/1ns
`include "usb_phy_settings.svh"

module usb_phy_tb;

  localparam int THR = `USB_BUS_RESET_CYCLES;
  localparam logic [1:0] ADDR_DRIVE = `USB_ADDR_DRIVE;
  localparam logic [1:0] ADDR_SENSE = `USB_ADDR_SENSE;
  localparam logic [1:0] ADDR_LINE  = `USB_ADDR_LINE;
  // Watchdog time is twice the summed test budgets in cycles
  localparam int BUDGET_CYCLES = 3000;
  localparam int WATCHDOG_NS   = BUDGET_CYCLES * 4 * 2;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        reg_wr;
  logic [1:0]                  reg_addr;
  logic [15:0]                 reg_wdata;
  usb_phy_pkg::reg_data_t      reg_rdata;
  usb_phy_pkg::usb_rx_pins_t   usb_rx;
  usb_phy_pkg::usb_tx_pins_t   eng_tx;
  usb_phy_pkg::usb_ctrl_pins_t eng_ctrl;
  usb_phy_pkg::usb_rx_pins_t   eng_rx;
  usb_phy_pkg::line_state_e    eng_line_state;
  logic                        eng_bus_reset;
  usb_phy_pkg::usb_tx_pins_t   usb_tx;
  usb_phy_pkg::usb_ctrl_pins_t usb_ctrl;

  // Model state with rx bits d, dp, dn and pwr_sense from bit 3 down
  logic [3:0] rx_meta_m;
  logic [3:0] rx_sync_m;
  logic [8:0] drive_m;
  int         cnt_m;
  logic       flag_m;

  int n_checks;
  int n_errors;
  int n_tests;
  int n_passed;
  int pulses_seen;

  always #2 clk = ~clk;

  usb_phy_top u_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .reg_wr_i         (reg_wr),
    .reg_addr_i       (reg_addr),
    .reg_wdata_i      (reg_wdata),
    .reg_rdata_o      (reg_rdata),
    .usb_rx_i         (usb_rx),
    .eng_tx_i         (eng_tx),
    .eng_ctrl_i       (eng_ctrl),
    .eng_rx_o         (eng_rx),
    .eng_line_state_o (eng_line_state),
    .eng_bus_reset_o  (eng_bus_reset),
    .usb_tx_o         (usb_tx),
    .usb_ctrl_o       (usb_ctrl)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Decode of dp and dn into the line_state_e codes
  function automatic logic [1:0] decode_line(input logic dp, input logic dn);
    if (!dp && !dn) return 2'd0;
    if (dp && !dn) return 2'd1;
    if (!dp && dn) return 2'd2;
    return 2'd3;
  endfunction

  function automatic logic line_is_se0();
    return (rx_sync_m[2] == 1'b0) && (rx_sync_m[1] == 1'b0);
  endfunction

  // Pulse on the edge that takes the run count up to the threshold
  function automatic logic expected_pulse();
    return line_is_se0() && (cnt_m + 1 == THR);
  endfunction

  // Drive word bits from 8 down are en oe se0 dn dp d rx_en dn_pu dp_pu
  function automatic logic [4:0] tx_from_word(input logic [8:0] w);
    return {w[3], w[6], w[4], w[5], w[7]};
  endfunction

  function automatic logic [2:0] ctrl_from_word(input logic [8:0] w);
    return {w[0], w[1], w[2]};
  endfunction

  function automatic logic [4:0] expected_tx();
    if (drive_m[8]) return tx_from_word(drive_m);
    return eng_tx;
  endfunction

  function automatic logic [2:0] expected_ctrl();
    if (drive_m[8]) return ctrl_from_word(drive_m);
    return eng_ctrl;
  endfunction

  function automatic logic [15:0] expected_rdata(input logic [1:0] addr);
    logic [15:0] w;
    w = '0;
    if (addr == ADDR_DRIVE) begin
      w[8:0] = drive_m;
    end else if (addr == ADDR_SENSE) begin
      // Engine request on top of the synchronized rx
      w[8:0] = {eng_tx.oe, eng_tx.se0, eng_tx.dn, eng_tx.dp, eng_tx.d,
                rx_sync_m[0], rx_sync_m[1], rx_sync_m[2], rx_sync_m[3]};
    end else if (addr == ADDR_LINE) begin
      w[2]   = flag_m;
      w[1:0] = decode_line(rx_sync_m[2], rx_sync_m[1]);
    end
    return w;
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      rx_meta_m <= '0;
      rx_sync_m <= '0;
      drive_m   <= '0;
      cnt_m     <= 0;
      flag_m    <= 1'b0;
    end else begin
      rx_meta_m <= usb_rx;
      rx_sync_m <= rx_meta_m;
      if (reg_wr && reg_addr == ADDR_DRIVE) begin
        drive_m <= reg_wdata[8:0];
      end
      // New pulse beats a clear in the same cycle
      if (expected_pulse()) begin
        flag_m <= 1'b1;
      end else if (reg_wr && reg_addr == ADDR_LINE && reg_wdata[2]) begin
        flag_m <= 1'b0;
      end
      if (line_is_se0()) begin
        cnt_m <= (cnt_m >= THR) ? THR : cnt_m + 1;
      end else begin
        cnt_m <= 0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] got);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Outputs are settled by the falling edge
  task automatic compare_outputs();
    check_val("usb_tx_o", 16'(expected_tx()), 16'(usb_tx));
    check_val("usb_ctrl_o", 16'(expected_ctrl()), 16'(usb_ctrl));
    check_val("eng_rx_o", 16'(rx_sync_m), 16'(eng_rx));
    check_val("eng_line_state_o", 16'(decode_line(rx_sync_m[2], rx_sync_m[1])),
              16'(eng_line_state));
    check_val("eng_bus_reset_o", 16'(expected_pulse()), 16'(eng_bus_reset));
    check_val("reg_rdata_o", expected_rdata(reg_addr), reg_rdata);
  endtask

  task automatic next_cycle();
    @(negedge clk);
    compare_outputs();
    if (eng_bus_reset) pulses_seen++;
  endtask

  task automatic randomize_engine();
    logic [31:0] rnd;
    rnd = $urandom;
    eng_tx   = rnd[4:0];
    eng_ctrl = rnd[7:5];
    reg_addr = rnd[9:8];
  endtask

  // Holds one line state on the pins for len cycles with random d and pwr_sense
  task automatic hold_line(input logic [1:0] state, input int len);
    logic [31:0] rnd;
    for (int i = 0; i < len; i++) begin
      rnd = $urandom;
      usb_rx = {rnd[0], (state == 2'd1 || state == 2'd3), (state == 2'd2 || state == 2'd3),
                rnd[1]};
      next_cycle();
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    n_tests++;
    if (n_errors == err_start) begin
      n_passed++;
      $display("test %-16s ok", name);
    end else begin
      $display("test %-16s failed with %0d errors", name, n_errors - err_start);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    int e0;
    e0 = n_errors;
    randomize_engine();
    reg_addr = ADDR_DRIVE;
    next_cycle();
    check_val("drive register", 16'h0000, reg_rdata);
    check_val("usb_tx_o", 16'(eng_tx), 16'(usb_tx));
    check_val("usb_ctrl_o", 16'(eng_ctrl), 16'(usb_ctrl));
    check_val("eng_bus_reset_o", 16'h0000, 16'(eng_bus_reset));
    reg_addr = ADDR_LINE;
    next_cycle();
    check_val("line flag", 16'h0000, 16'(reg_rdata[2]));
    report_test("reset_state", e0);
  endtask

  task automatic passthrough();
    int e0;
    e0 = n_errors;
    for (int i = 0; i < 300; i++) begin
      randomize_engine();
      usb_rx = 4'($urandom);
      next_cycle();
    end
    report_test("passthrough", e0);
  endtask

  task automatic override_drive();
    int          e0;
    logic [31:0] rnd;
    logic [15:0] wdata;
    e0 = n_errors;
    for (int n = 0; n < 40; n++) begin
      rnd   = $urandom;
      wdata = {rnd[15:9], 1'b1, rnd[7:0]};
      randomize_engine();
      reg_wr    = 1'b1;
      reg_addr  = ADDR_DRIVE;
      reg_wdata = wdata;
      next_cycle();
      reg_wr = 1'b0;
      check_val("usb_tx_o", 16'(tx_from_word(wdata[8:0])), 16'(usb_tx));
      check_val("usb_ctrl_o", 16'(ctrl_from_word(wdata[8:0])), 16'(usb_ctrl));
      // Engine keeps toggling while the override holds
      for (int k = 0; k <= int'(rnd[17:16]); k++) begin
        randomize_engine();
        next_cycle();
      end
    end
    // Clearing en hands the pins back to the engine
    rnd       = $urandom;
    reg_wr    = 1'b1;
    reg_addr  = ADDR_DRIVE;
    reg_wdata = {8'h00, rnd[7:0]};
    next_cycle();
    reg_wr = 1'b0;
    check_val("usb_tx_o", 16'(eng_tx), 16'(usb_tx));
    check_val("usb_ctrl_o", 16'(eng_ctrl), 16'(usb_ctrl));
    report_test("override_drive", e0);
  endtask

  task automatic rx_sync_sense();
    int e0;
    e0 = n_errors;
    for (int i = 0; i < 500; i++) begin
      randomize_engine();
      reg_addr = ADDR_SENSE;
      usb_rx   = 4'($urandom);
      next_cycle();
    end
    report_test("rx_sync_sense", e0);
  endtask

  task automatic line_state_reset();
    int e0;
    int long_runs;
    e0 = n_errors;
    long_runs = 0;
    reg_addr = ADDR_LINE;
    hold_line(2'd1, 4);
    pulses_seen = 0;
    // SE0 runs alternate with other states and go short and long in turn
    for (int r = 0; r < 50; r++) begin
      if (r % 4 == 0) begin
        hold_line(2'd0, $urandom_range(THR - 1, 1));
      end else if (r % 4 == 2) begin
        long_runs++;
        hold_line(2'd0, $urandom_range(THR + 20, THR));
      end else begin
        hold_line(2'($urandom_range(3, 1)), $urandom_range(6, 1));
      end
    end
    hold_line(2'd1, 3);
    n_checks++;
    assert (pulses_seen == long_runs) else begin
      n_errors++;
      $display("bus reset pulse count wrong: %0d long SE0 runs but %0d pulses",
               long_runs, pulses_seen);
    end
    report_test("line_state_reset", e0);
  endtask

  task automatic sticky_flag();
    int   e0;
    logic seen;
    e0 = n_errors;
    reg_addr = ADDR_LINE;
    // Start from a clear flag so that the set below comes from this run
    reg_wr    = 1'b1;
    reg_wdata = 16'h0004;
    hold_line(2'd1, 1);
    reg_wr = 1'b0;
    check_val("line flag", 16'h0000, 16'(reg_rdata[2]));
    hold_line(2'd1, 2);
    hold_line(2'd0, THR + 4);
    hold_line(2'd1, 4);
    check_val("line flag", 16'h0001, 16'(reg_rdata[2]));
    // Clear and then clear again with no reset in between
    for (int n = 0; n < 2; n++) begin
      reg_wr    = 1'b1;
      reg_wdata = 16'h0004;
      next_cycle();
      reg_wr = 1'b0;
      check_val("line flag", 16'h0000, 16'(reg_rdata[2]));
      hold_line(2'd2, 3);
      check_val("line flag", 16'h0000, 16'(reg_rdata[2]));
    end
    // A clear in the pulse cycle loses to the set
    seen = 1'b0;
    for (int i = 0; i < THR + 8 && !seen; i++) begin
      hold_line(2'd0, 1);
      seen = eng_bus_reset;
    end
    n_checks++;
    assert (seen) else begin
      n_errors++;
      $display("no bus reset pulse seen within %0d cycles of SE0", THR + 8);
    end
    reg_wr    = 1'b1;
    reg_wdata = 16'h0004;
    hold_line(2'd1, 1);
    reg_wr = 1'b0;
    check_val("line flag", 16'h0001, 16'(reg_rdata[2]));
    report_test("sticky_flag", e0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned seed;
    seed      = $urandom(68091);
    rst_n     = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    usb_rx    = '0;
    eng_tx    = '0;
    eng_ctrl  = '0;
    n_checks  = 0;
    n_errors  = 0;
    n_tests   = 0;
    n_passed  = 0;
    pulses_seen = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_state();
    passthrough();
    override_drive();
    rx_sync_sense();
    line_state_reset();
    sticky_flag();
    $display("tests %0d, passed %0d, checks %0d, errors %0d",
             n_tests, n_passed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: project.f
+incdir+hdl
hdl/usb_phy_pkg.sv
hdl/usb_phy_regs.sv
hdl/usb_phy_iomux.sv
hdl/usb_line_monitor.sv
hdl/usb_phy_top.sv
test/usb_phy_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the USB PHY front end testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module usb_phy_tb -o usb_phy_sim

./obj_dir/usb_phy_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '** PASS **' sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
